/* vlog.f */
src/isaPkg.sv
src/pipePkg.sv
src/registerFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/pipelineCpu.sv
test/pipelineCpuTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = pipelineCpuTb
FILELIST = vlog.f
OBJDIR = obj_dir
PASS = all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS)"

clean:
	rm -rf $(OBJDIR)

/* test/pipelineCpuTb.sv */
`timescale 1ns/1ps

module pipelineCpuTb;
	import isaPkg::*;
	import pipePkg::*;

	localparam int dataDepth = 64;
	localparam int writeTimeout = 20; // cycles allowed between two writes
	localparam int quietCycles = 30;  // tail with no writes expected

	logic clk;
	logic reset;
	wordT imemAddr, imemData;
	logic wbEn;
	regAddrT wbReg;
	wordT wbData;

	// program table, one row per instruction word
	wordT progWord [32];
	logic expWrite [32];
	regAddrT expReg [32];
	wordT expValue [32];
	string rowName [32];
	int rowCount;
	logic [15:0] memOff; // random byte offset for sw/lw

	// instruction memory served from the table, no-op past the end
	assign imemData = (imemAddr[31:7] == '0) ? progWord[imemAddr[6:2]] : '0;

	pipelineCpu #(.dataDepth(dataDepth)) pipelineCpu_inst (.clk(clk), .reset(reset),
		.imemAddr(imemAddr), .imemData(imemData), .wbEn(wbEn), .wbReg(wbReg),
		.wbData(wbData));

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic wordT rTypeWord(functE fn, regAddrT rs, regAddrT rt, regAddrT rd);
		return {opRtype, rs, rt, rd, 5'd0, fn}; // shamt always zero
	endfunction

	function automatic wordT iTypeWord(opcodeE op, regAddrT rs, regAddrT rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic addRow(input wordT word, input logic wr, input regAddrT dest,
		input wordT value, input string name);
		progWord[rowCount] = word;
		expWrite[rowCount] = wr;
		expReg[rowCount] = dest;
		expValue[rowCount] = value;
		rowName[rowCount] = name;
		rowCount++;
	endtask

	task automatic stopRun();
		$display("tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			stopRun();
		end
	endtask

	// sample at negedge, wbEn is a one-cycle pulse
	task automatic waitForWrite(input string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (wbEn !== 1'b1)
		begin
			cycles++;
			if (cycles > writeTimeout)
			begin
				$display("no register write arrived for %s within %0d cycles", name,
					writeTimeout);
				stopRun();
			end
			@(negedge clk);
		end
	endtask

	task automatic buildProgram();
		int unsigned pick;
		for (int i = 0; i < 32; i++)
		begin
			progWord[i] = '0;
			expWrite[i] = 1'b0;
			expReg[i] = '0;
			expValue[i] = '0;
			rowName[i] = "nop";
		end
		rowCount = 0;
		pick = $urandom() % dataDepth; // word index inside data RAM
		memOff = 16'(pick * 4);
		$display("data address %0d", memOff);
		// alu chain, values worked out by hand from the ISA
		addRow(iTypeWord(opAddi, 5'd0, 5'd1, 16'd5), 1'b1, 5'd1, 32'd5, "addi r1");
		addRow(iTypeWord(opAddi, 5'd1, 5'd2, 16'd7), 1'b1, 5'd2, 32'd12, "addi exmem fwd");
		addRow(iTypeWord(opAddi, 5'd0, 5'd3, 16'hFFEC), 1'b1, 5'd3, 32'hFFFFFFEC,
			"addi negative"); // -20
		addRow(rTypeWord(fnAdd, 5'd1, 5'd2, 5'd4), 1'b1, 5'd4, 32'd17, "add bypass");
		addRow(rTypeWord(fnSub, 5'd3, 5'd1, 5'd5), 1'b1, 5'd5, 32'hFFFFFFE7,
			"sub memwb fwd"); // -20 - 5
		addRow(rTypeWord(fnAnd, 5'd4, 5'd5, 5'd6), 1'b1, 5'd6, 32'd1, "and"); // 17 & -25
		addRow(rTypeWord(fnOr, 5'd2, 5'd6, 5'd7), 1'b1, 5'd7, 32'd13, "or");
		addRow(rTypeWord(fnSlt, 5'd5, 5'd1, 5'd8), 1'b1, 5'd8, 32'd1, "slt negative");
		addRow(rTypeWord(fnSlt, 5'd7, 5'd6, 5'd9), 1'b1, 5'd9, 32'd0, "slt false");
		// store, load, load-use add
		addRow(iTypeWord(opAddi, 5'd0, 5'd10, 16'h1234), 1'b1, 5'd10, 32'h1234, "addi store");
		addRow(iTypeWord(opSw, 5'd0, 5'd10, memOff), 1'b0, 5'd0, 32'd0, "sw");
		addRow(iTypeWord(opLw, 5'd0, 5'd11, memOff), 1'b1, 5'd11, 32'h1234, "lw");
		addRow(rTypeWord(fnAdd, 5'd11, 5'd10, 5'd12), 1'b1, 5'd12, 32'h2468, "add load-use");
		// taken beq on a fresh source skips two rows
		addRow(iTypeWord(opAddi, 5'd0, 5'd13, 16'd5), 1'b1, 5'd13, 32'd5, "addi beq src");
		addRow(iTypeWord(opBeq, 5'd13, 5'd1, 16'd2), 1'b0, 5'd0, 32'd0, "beq taken");
		addRow(iTypeWord(opAddi, 5'd0, 5'd14, 16'd99), 1'b0, 5'd0, 32'd0, "flushed");
		addRow(iTypeWord(opAddi, 5'd0, 5'd15, 16'd77), 1'b0, 5'd0, 32'd0, "jumped over");
		addRow(iTypeWord(opAddi, 5'd13, 5'd16, 16'd1), 1'b1, 5'd16, 32'd6, "branch target");
		// not-taken beq, then r0 write and r0 read
		addRow(iTypeWord(opBeq, 5'd1, 5'd2, 16'd1), 1'b0, 5'd0, 32'd0, "beq not taken");
		addRow(iTypeWord(opAddi, 5'd0, 5'd17, 16'd42), 1'b1, 5'd17, 32'd42, "after beq");
		addRow(iTypeWord(opAddi, 5'd1, 5'd0, 16'd9), 1'b0, 5'd0, 32'd0, "write r0");
		addRow(rTypeWord(fnAdd, 5'd0, 5'd1, 5'd18), 1'b1, 5'd18, 32'd5, "read r0");
	endtask

	initial
	begin
		reset = 1'b1;
		void'($urandom(32'h69cff42f));
		buildProgram();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkValue("reset pc", 32'd0, imemAddr);
		checkValue("reset wbEn", 32'd0, 32'(wbEn));
		for (int i = 0; i < rowCount; i++)
		begin
			if (expWrite[i])
			begin
				waitForWrite(rowName[i]);
				checkValue({rowName[i], " dest"}, 32'(expReg[i]), 32'(wbReg));
				checkValue({rowName[i], " data"}, expValue[i], wbData);
			end
		end
		// only no-ops left, nothing may write now
		for (int i = 0; i < quietCycles; i++)
		begin
			@(negedge clk);
			if (wbEn !== 1'b0)
			begin
				$display("an extra register write to r%0d appeared after the program", wbReg);
				stopRun();
			end
		end
		$display("all tests passed");
		$finish;
	end

endmodule

/* src/pipelineCpu.sv */
`timescale 1ns/1ps

module pipelineCpu #(
	parameter int dataDepth = 64
) (
	input  logic             clk,
	input  logic             reset,
	output pipePkg::wordT    imemAddr,
	input  pipePkg::wordT    imemData,
	output logic             wbEn,
	output pipePkg::regAddrT wbReg,
	output pipePkg::wordT    wbData
);
	import pipePkg::*;

	wordT pc, pcPlus4, ifInstr, ifPcPlus4, branchTarget;
	logic stall, branchTaken;
	// id/ex contents
	logic idRegWrite, idMemRead, idMemWrite, idAluSrc;
	aluOpE idAluOp;
	wordT idOpA, idOpB, idImm;
	regAddrT idRs, idRt, idDest;
	// ex/mem contents
	logic exRegWrite, exMemRead, exMemWrite;
	regAddrT exDest;
	wordT exAluResult, exStoreData;

	assign imemAddr = pc;
	assign pcPlus4 = pc + 32'd4; // fetch adder

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
			ifInstr <= '0; // no-op
		end
		else if (branchTaken)
		begin
			pc <= branchTarget;
			ifInstr <= '0; // squash the slot behind beq
		end
		else if (!stall) // stall holds both
		begin
			pc <= pcPlus4;
			ifInstr <= imemData;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
			ifPcPlus4 <= pcPlus4;
	end

	decodeStage decodeStage_inst (.clk(clk), .reset(reset), .instr(ifInstr), .pcPlus4(ifPcPlus4),
		.stall(stall), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.exRegWrite(idRegWrite), .exMemRead(idMemRead), .exDest(idDest),
		.memRegWrite(exRegWrite), .memMemRead(exMemRead), .memDest(exDest),
		.memAluResult(exAluResult), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.idRegWrite(idRegWrite), .idMemRead(idMemRead), .idMemWrite(idMemWrite),
		.idAluSrc(idAluSrc), .idAluOp(idAluOp), .idOpA(idOpA), .idOpB(idOpB), .idImm(idImm),
		.idRs(idRs), .idRt(idRt), .idDest(idDest));

	executeStage executeStage_inst (.clk(clk), .reset(reset), .idRegWrite(idRegWrite),
		.idMemRead(idMemRead), .idMemWrite(idMemWrite), .idAluSrc(idAluSrc), .idAluOp(idAluOp),
		.idOpA(idOpA), .idOpB(idOpB), .idImm(idImm), .idRs(idRs), .idRt(idRt), .idDest(idDest),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .exRegWrite(exRegWrite),
		.exMemRead(exMemRead), .exMemWrite(exMemWrite), .exDest(exDest),
		.exAluResult(exAluResult), .exStoreData(exStoreData));

	memoryStage #(.dataDepth(dataDepth)) memoryStage_inst (.clk(clk), .reset(reset),
		.exRegWrite(exRegWrite), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
		.exDest(exDest), .exAluResult(exAluResult), .exStoreData(exStoreData),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData));

	assert property (@(posedge clk) disable iff (reset) imemAddr[1:0] == 2'b00);

endmodule

/* src/memoryStage.sv */
`timescale 1ns/1ps

module memoryStage #(
	parameter int dataDepth = 64
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             exRegWrite,
	input  logic             exMemRead,
	input  logic             exMemWrite,
	input  pipePkg::regAddrT exDest,
	input  pipePkg::wordT    exAluResult,
	input  pipePkg::wordT    exStoreData,
	output logic             wbEn,
	output pipePkg::regAddrT wbReg,
	output pipePkg::wordT    wbData
);
	import pipePkg::*;

	localparam int addrW = $clog2(dataDepth);

	wordT ram [dataDepth];
	logic [addrW-1:0] ramIdx;
	wordT loadData;

	assign ramIdx = exAluResult[addrW+1:2]; // word address
	assign loadData = ram[ramIdx]; // async read

	always_ff @(posedge clk)
	begin
		if (exMemWrite)
			ram[ramIdx] <= exStoreData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			wbEn <= 1'b0;
		else
			wbEn <= exRegWrite && exDest != '0; // r0 writes dropped here
		wbReg <= exDest;
		wbData <= exMemRead ? loadData : exAluResult;
	end

	assert property (@(posedge clk) disable iff (reset)
		(exMemRead || exMemWrite) |-> (exAluResult >> 2) < dataDepth);

endmodule

/* src/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input  logic             clk,
	input  logic             reset,
	input  logic             idRegWrite,
	input  logic             idMemRead,
	input  logic             idMemWrite,
	input  logic             idAluSrc,
	input  pipePkg::aluOpE   idAluOp,
	input  pipePkg::wordT    idOpA,
	input  pipePkg::wordT    idOpB,
	input  pipePkg::wordT    idImm,
	input  pipePkg::regAddrT idRs,
	input  pipePkg::regAddrT idRt,
	input  pipePkg::regAddrT idDest,
	input  logic             wbEn,
	input  pipePkg::regAddrT wbReg,
	input  pipePkg::wordT    wbData,
	output logic             exRegWrite,
	output logic             exMemRead,
	output logic             exMemWrite,
	output pipePkg::regAddrT exDest,
	output pipePkg::wordT    exAluResult,
	output pipePkg::wordT    exStoreData
);
	import pipePkg::*;
	import isaPkg::*;

	aluCtrlE aluCtrl;
	functE funct;
	fwdSelE fwdA, fwdB;
	wordT opA, rtVal, opB, result;

	assign funct = functE'(idImm[functMsb:functLsb]); // funct sits in the low imm bits

	always_comb
	begin
		case (idAluOp)
			aopSub: aluCtrl = aluSub;
			aopFunct:
				case (funct)
					fnSub:   aluCtrl = aluSub;
					fnAnd:   aluCtrl = aluAnd;
					fnOr:    aluCtrl = aluOr;
					fnSlt:   aluCtrl = aluSlt;
					default: aluCtrl = aluAdd; // fnAdd and no-op
				endcase
			default: aluCtrl = aluAdd;
		endcase
	end

	// ex/mem first, then mem/wb (wbEn already false for r0)
	assign fwdA = (exRegWrite && exDest != '0 && exDest == idRs) ? fwdMemStage :
		(wbEn && wbReg == idRs) ? fwdWbStage : fwdNone;
	assign fwdB = (exRegWrite && exDest != '0 && exDest == idRt) ? fwdMemStage :
		(wbEn && wbReg == idRt) ? fwdWbStage : fwdNone;

	assign opA = (fwdA == fwdMemStage) ? exAluResult : (fwdA == fwdWbStage) ? wbData : idOpA;
	assign rtVal = (fwdB == fwdMemStage) ? exAluResult : (fwdB == fwdWbStage) ? wbData : idOpB;
	assign opB = idAluSrc ? idImm : rtVal; // store data keeps rtVal

	always_comb
	begin
		case (aluCtrl)
			aluSub:  result = opA - opB;
			aluAnd:  result = opA & opB;
			aluOr:   result = opA | opB;
			aluSlt:  result = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0; // signed compare
			default: result = opA + opB;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			{exRegWrite, exMemRead, exMemWrite} <= '0;
		else
			{exRegWrite, exMemRead, exMemWrite} <= {idRegWrite, idMemRead, idMemWrite};
	end

	always_ff @(posedge clk)
	begin
		exDest <= idDest;
		exAluResult <= result;
		exStoreData <= rtVal;
	end

	// load-use stall in decode must keep a load out of this path
	assert property (@(posedge clk) disable iff (reset)
		(fwdA == fwdMemStage || fwdB == fwdMemStage) |-> !exMemRead);

endmodule

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
	input  logic             clk,
	input  logic             reset,
	input  pipePkg::wordT    instr,
	input  pipePkg::wordT    pcPlus4,
	output logic             stall,
	output logic             branchTaken,
	output pipePkg::wordT    branchTarget,
	input  logic             exRegWrite,   // instruction now in execute
	input  logic             exMemRead,
	input  pipePkg::regAddrT exDest,
	input  logic             memRegWrite,  // instruction now in memory
	input  logic             memMemRead,
	input  pipePkg::regAddrT memDest,
	input  pipePkg::wordT    memAluResult,
	input  logic             wbEn,
	input  pipePkg::regAddrT wbReg,
	input  pipePkg::wordT    wbData,
	output logic             idRegWrite,
	output logic             idMemRead,
	output logic             idMemWrite,
	output logic             idAluSrc,
	output pipePkg::aluOpE   idAluOp,
	output pipePkg::wordT    idOpA,
	output pipePkg::wordT    idOpB,
	output pipePkg::wordT    idImm,
	output pipePkg::regAddrT idRs,
	output pipePkg::regAddrT idRt,
	output pipePkg::regAddrT idDest
);
	import pipePkg::*;
	import isaPkg::*;

	opcodeE op;
	regAddrT rs, rt, dest;
	wordT imm, rdDataA, rdDataB, brA, brB;
	logic regWrite, memRead, memWrite, aluSrc, usesRs, usesRt, isBeq, loadUse, brHazard;
	aluOpE aluOp;

	assign op = opcodeE'(instr[opcodeMsb:opcodeLsb]);
	assign rs = instr[rsMsb:rsLsb];
	assign rt = instr[rtMsb:rtLsb];
	assign imm = {{16{instr[immMsb]}}, instr[immMsb:immLsb]}; // sign extend

	registerFile regFile_inst (.clk(clk), .reset(reset), .rdAddrA(rs), .rdAddrB(rt),
		.rdDataA(rdDataA), .rdDataB(rdDataB), .wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData));

	always_comb
	begin
		{regWrite, memRead, memWrite, aluSrc, usesRs, usesRt, isBeq} = '0; // no-op
		aluOp = aopAdd;
		dest = '0;
		case (op)
			opRtype:
			begin
				regWrite = 1'b1;
				aluOp = aopFunct;
				usesRs = 1'b1;
				usesRt = 1'b1;
				dest = instr[rdMsb:rdLsb];
			end
			opAddi:
			begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				usesRs = 1'b1;
				dest = rt;
			end
			opLw:
			begin
				regWrite = 1'b1;
				memRead = 1'b1;
				aluSrc = 1'b1;
				usesRs = 1'b1;
				dest = rt;
			end
			opSw:
			begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			opBeq:
			begin
				isBeq = 1'b1;
				aluOp = aopSub;
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			default: ; // unknown opcode stays a no-op
		endcase
	end

	// load in execute feeding this instruction
	assign loadUse = exMemRead && exDest != '0 &&
		((usesRs && exDest == rs) || (usesRt && exDest == rt));
	// beq waits for anything in execute and for a load in memory
	assign brHazard = isBeq && ((exRegWrite && exDest != '0 && (exDest == rs || exDest == rt)) ||
		(memMemRead && memDest != '0 && (memDest == rs || memDest == rt)));
	assign stall = loadUse || brHazard;

	// branch operands take the ex/mem result and reach wb through the regfile bypass
	assign brA = (memRegWrite && memDest != '0 && memDest == rs) ? memAluResult : rdDataA;
	assign brB = (memRegWrite && memDest != '0 && memDest == rt) ? memAluResult : rdDataB;
	assign branchTaken = isBeq && !brHazard && (brA == brB); // load-use on beq is a brHazard too
	assign branchTarget = pcPlus4 + (imm << 2);

	always_ff @(posedge clk)
	begin
		if (reset || stall) // bubble
			{idRegWrite, idMemRead, idMemWrite, idAluSrc} <= '0;
		else
			{idRegWrite, idMemRead, idMemWrite, idAluSrc} <= {regWrite, memRead, memWrite, aluSrc};
	end

	always_ff @(posedge clk)
	begin
		idAluOp <= aluOp;
		idOpA <= rdDataA;
		idOpB <= rdDataB;
		idImm <= imm;
		idRs <= (usesRs && !stall) ? rs : '0; // unused source never forwards
		idRt <= (usesRt && !stall) ? rt : '0;
		idDest <= dest;
	end

	assert property (@(posedge clk) disable iff (reset) !(stall && branchTaken));

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
	input  logic             clk,
	input  logic             reset,
	input  pipePkg::regAddrT rdAddrA,
	input  pipePkg::regAddrT rdAddrB,
	output pipePkg::wordT    rdDataA,
	output pipePkg::wordT    rdDataB,
	input  logic             wrEn,
	input  pipePkg::regAddrT wrAddr,
	input  pipePkg::wordT    wrData
);
	import pipePkg::*;

	wordT regs [32];

	// r0 reads zero, same-cycle write is bypassed to the readers
	assign rdDataA = (rdAddrA == '0) ? '0 : (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wrEn && wrAddr != '0) // r0 never written
			regs[wrAddr] <= wrData;
	end

endmodule

/* src/pipePkg.sv */
// types that travel between the pipeline stages
package pipePkg;

	typedef logic [31:0] wordT;   // data word
	typedef logic [4:0] regAddrT; // register index

	// alu class chosen in decode
	typedef enum logic [1:0] {
		aopAdd,   // address calc, addi
		aopSub,   // compare
		aopFunct  // look at funct
	} aluOpE;

	// resolved alu operation in execute
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluCtrlE;

	// operand forwarding source, memStage wins over wbStage
	typedef enum logic [1:0] {
		fwdNone,
		fwdMemStage,
		fwdWbStage
	} fwdSelE;

endpackage

/* src/isaPkg.sv */
// MIPS instruction encoding shared by the decoder and the testbench
package isaPkg;

	// major opcodes, unknown values decode as no-op
	typedef enum logic [5:0] {
		opRtype = 6'd0,
		opBeq   = 6'd4,
		opAddi  = 6'd8,
		opLw    = 6'd35,
		opSw    = 6'd43
	} opcodeE;

	// r-type function codes
	typedef enum logic [5:0] {
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr  = 6'd37,
		fnSlt = 6'd42
	} functE;

	// field positions in the instruction word
	localparam int opcodeMsb = 31, opcodeLsb = 26;
	localparam int rsMsb = 25, rsLsb = 21;
	localparam int rtMsb = 20, rtLsb = 16;
	localparam int rdMsb = 15, rdLsb = 11;
	localparam int functMsb = 5, functLsb = 0;
	localparam int immMsb = 15, immLsb = 0; // low half, sign bit at immMsb

endpackage
